// File: dv/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_model #(
    parameter ADDR_WIDTH = 20,
    parameter DATA_WIDTH = 16
)(
    input  logic                  clk,
    input  logic                  i_ce_n,
    input  logic                  i_oe_n,
    input  logic                  i_we_n,
    input  logic                  i_lb_n,
    input  logic                  i_ub_n,
    input  logic [ADDR_WIDTH-1:0] i_addr,
    inout  wire  [DATA_WIDTH-1:0] io_dq
);

    logic [DATA_WIDTH-1:0] mem [0:(2**ADDR_WIDTH)-1];
    logic                  rd_en;

    // every address bit shows up in the fill.
    initial begin
        for (int a = 0; a < 2**ADDR_WIDTH; a++) begin
            mem[a] = DATA_WIDTH'(a) ^ DATA_WIDTH'(a >> 4) ^ DATA_WIDTH'(16'h5a5a);
        end
    end

    // --------------------
    // write lanes
    // --------------------

    // write commits at the end of each bus cycle.
    always @(posedge clk) begin
        if (!i_ce_n && !i_we_n) begin
            if (!i_lb_n) mem[i_addr][7:0] = io_dq[7:0];
            if (!i_ub_n) mem[i_addr][15:8] = io_dq[15:8];
        end
    end

    assign rd_en = !i_ce_n && !i_oe_n && i_we_n;
    assign io_dq = rd_en ? mem[i_addr] : 'z;  // released otherwise.

endmodule

`default_nettype wire

// File: dv/tb_dbg_board.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_board;

    import dbg_pkg::*;

    localparam int DATA_WIDTH   = 32;
    localparam int RAT_DEPTH    = 32;
    localparam int RDST_W       = $clog2(RAT_DEPTH);
    localparam int WB_BASE      = 0;
    localparam int WIN_BYTES    = 2 * (2 ** SRAM_ADDR_WIDTH);
    localparam int HEX_W        = HEX_DIGITS * SEG_WIDTH;
    localparam int NUM_STEPS    = 22;
    localparam int ACK_WAIT_MAX = 8;

    // active low, a in bit 0.
    localparam logic [SEG_WIDTH-1:0] FONT [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    typedef enum logic [2:0] {
        K_RETIRE,
        K_KEY_DOWN,
        K_KEY_UP,
        K_WB_WRITE,
        K_WB_READ
    } step_kind_e;

    typedef struct packed {
        step_kind_e        kind;
        logic [RDST_W-1:0] rdst;
        logic [31:0]       data;
        logic [31:0]       addr;
        logic [3:0]        sel;
        logic [31:0]       exp_word;
        logic [1:0]        exp_lat;
        logic              exp_core_en;
        logic [RDST_W-1:0] exp_rdst;
        logic [31:0]       exp_data;
    } step_t;

    // retire, ignored retire, resume, capture with key held, release, resume.
    localparam step_kind_e KEY_SEQ [7] = '{
        K_RETIRE, K_RETIRE, K_KEY_DOWN, K_RETIRE, K_KEY_UP, K_KEY_DOWN, K_KEY_UP
    };

    logic                        clk;
    logic                        n_rst;
    logic                        i_key_n;
    logic                        i_retire_en;
    logic [RDST_W-1:0]           i_retire_rdst;
    logic [DATA_WIDTH-1:0]       i_retire_data;
    logic                        i_redirect;
    logic [31:0]                 i_redirect_addr;
    logic                        i_wb_cyc;
    logic                        i_wb_stb;
    logic                        i_wb_we;
    logic [WB_CTI_WIDTH-1:0]     i_wb_cti;
    logic [WB_BTE_WIDTH-1:0]     i_wb_bte;
    logic [3:0]                  i_wb_sel;
    logic [31:0]                 i_wb_addr;
    logic [31:0]                 i_wb_data;
    logic [31:0]                 o_wb_data;
    logic                        o_wb_ack;
    logic                        o_core_en;
    logic [17:0]                 o_ledr;
    logic [7:0]                  o_ledg;
    logic [HEX_W-1:0]            o_hex;
    logic                        o_sram_ce_n;
    logic                        o_sram_oe_n;
    logic                        o_sram_we_n;
    logic                        o_sram_lb_n;
    logic                        o_sram_ub_n;
    logic [SRAM_ADDR_WIDTH-1:0]  o_sram_addr;
    wire  [SRAM_DATA_WIDTH-1:0]  sram_dq;

    step_t       steps [NUM_STEPS];
    logic [31:0] rand_state;
    int          cur_step;
    int          value_errs;
    int          other_errs;

    dbg_board_top #(
        .OPTN_DATA_WIDTH(DATA_WIDTH),
        .OPTN_RAT_DEPTH(RAT_DEPTH),
        .OPTN_ADDR_WIDTH(32),
        .OPTN_WB_ADDR_WIDTH(32),
        .OPTN_WB_SRAM_BASE_ADDR(WB_BASE)
    ) DUT (
        .clk(clk), .n_rst(n_rst), .i_key_n(i_key_n),
        .i_retire_en(i_retire_en), .i_retire_rdst(i_retire_rdst),
        .i_retire_data(i_retire_data), .i_redirect(i_redirect),
        .i_redirect_addr(i_redirect_addr),
        .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
        .i_wb_cti(i_wb_cti), .i_wb_bte(i_wb_bte), .i_wb_sel(i_wb_sel),
        .i_wb_addr(i_wb_addr), .i_wb_data(i_wb_data),
        .o_wb_data(o_wb_data), .o_wb_ack(o_wb_ack),
        .o_core_en(o_core_en), .o_ledr(o_ledr), .o_ledg(o_ledg), .o_hex(o_hex),
        .o_sram_ce_n(o_sram_ce_n), .o_sram_oe_n(o_sram_oe_n),
        .o_sram_we_n(o_sram_we_n), .o_sram_lb_n(o_sram_lb_n),
        .o_sram_ub_n(o_sram_ub_n), .o_sram_addr(o_sram_addr), .io_sram_dq(sram_dq)
    );

    sram_model sram (
        .clk(clk), .i_ce_n(o_sram_ce_n), .i_oe_n(o_sram_oe_n), .i_we_n(o_sram_we_n),
        .i_lb_n(o_sram_lb_n), .i_ub_n(o_sram_ub_n), .i_addr(o_sram_addr), .io_dq(sram_dq)
    );

    always #20 clk = ~clk;

    // --------------------
    // helpers
    // --------------------

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [HEX_W-1:0] expected_hex(input logic [31:0] value);
        logic [HEX_W-1:0] h;
        for (int i = 0; i < HEX_DIGITS; i++) begin
            h[i*SEG_WIDTH +: SEG_WIDTH] = FONT[value[i*4 +: 4]];
        end
        return h;
    endfunction

    task automatic check_hex(input string name, input logic [HEX_W-1:0] got,
                             input logic [HEX_W-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] step %0d %s: got 0x%h, expected 0x%h", cur_step, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] step %0d %s: got 0x%h, expected 0x%h", cur_step, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] step %0d %s: got 0x%h, expected 0x%h", cur_step, name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    // key-path steps carry a redirect in addr and sel[0].
    task automatic drive_redirect(input step_t s);
        i_redirect = s.sel[0];
        i_redirect_addr = s.addr;
    endtask

    task automatic check_key_path(input step_t s);
        check_bit("o_core_en", o_core_en, s.exp_core_en);
        check_bit("o_ledr[17]", o_ledr[17], ~s.exp_core_en);
        check_bit("o_ledr[16]", o_ledr[16], s.sel[0]);
        check_word("o_ledr[15:0]", 32'(o_ledr[15:0]), 32'(s.addr[15:0]));
        check_word("o_ledg", 32'(o_ledg), 32'(s.exp_rdst));
        check_hex("o_hex", o_hex, expected_hex(s.exp_data));
    endtask

    // --------------------
    // stimulus table
    // --------------------

    task automatic build_table();
        logic [31:0]       slot_addr [4];
        logic [31:0]       shadow [4];
        logic [31:0]       base;
        logic [31:0]       wdata;
        logic [3:0]        sel;
        logic [RDST_W-1:0] cap_rdst;
        logic [31:0]       cap_data;
        logic              run;
        int                n;
        cap_rdst = '0;
        cap_data = '0;
        run = 1'b1;
        n = 0;
        for (int i = 0; i < 7; i++) begin
            steps[n] = '0;
            steps[n].kind = KEY_SEQ[i];
            steps[n].rdst = RDST_W'(next_rand());
            steps[n].data = next_rand();
            steps[n].addr = next_rand();
            steps[n].sel = 4'(next_rand() >> 7);
            if (KEY_SEQ[i] == K_RETIRE && run) begin
                cap_rdst = steps[n].rdst;
                cap_data = steps[n].data;
                run = 1'b0;
            end else if (KEY_SEQ[i] == K_KEY_DOWN) begin
                run = 1'b1;
            end
            steps[n].exp_core_en = run;
            steps[n].exp_rdst = cap_rdst;
            steps[n].exp_data = cap_data;
            n++;
        end
        base = next_rand() & 32'h001f_fff0;
        for (int i = 0; i < 4; i++) begin
            slot_addr[i] = base + 32'(i * 4);
            shadow[i] = '0;
        end
        // full writes, partial writes, then reads.
        for (int pass = 0; pass < 3; pass++) begin
            for (int i = 0; i < 4; i++) begin
                steps[n] = '0;
                steps[n].addr = slot_addr[i];
                steps[n].exp_lat = 2'd3;
                if (pass == 2) begin
                    steps[n].kind = K_WB_READ;
                    steps[n].exp_word = shadow[i];
                end else begin
                    wdata = next_rand();
                    sel = (pass == 0) ? 4'hf : 4'(next_rand() >> 13);
                    for (int b = 0; b < 4; b++) begin
                        if (sel[b]) shadow[i][b*8 +: 8] = wdata[b*8 +: 8];
                    end
                    steps[n].kind = K_WB_WRITE;
                    steps[n].data = wdata;
                    steps[n].sel = sel;
                end
                n++;
            end
        end
        // outside the window but aliasing slot 0.
        steps[n] = '0;
        steps[n].kind = K_WB_WRITE;
        steps[n].addr = 32'(WB_BASE + WIN_BYTES) + slot_addr[0];
        steps[n].sel = 4'hf;
        steps[n].data = next_rand();
        steps[n].exp_lat = 2'd1;
        steps[n+1] = steps[n];
        steps[n+1].kind = K_WB_READ;
        steps[n+2] = '0;
        steps[n+2].kind = K_WB_READ;
        steps[n+2].addr = slot_addr[0];
        steps[n+2].exp_lat = 2'd3;
        steps[n+2].exp_word = shadow[0];
    endtask

    // --------------------
    // step drivers
    // --------------------

    task automatic run_retire(input step_t s);
        drive_redirect(s);
        i_retire_en = 1'b1;
        i_retire_rdst = s.rdst;
        i_retire_data = s.data;
        next_cycle();
        i_retire_en = 1'b0;
        check_bit("o_core_en", o_core_en, 1'b0);  // drops on the capture edge.
        next_cycle();
        check_key_path(s);
    endtask

    task automatic press_key(input step_t s);
        int n;
        n = 0;
        drive_redirect(s);
        i_key_n = 1'b0;
        while (!o_core_en && n < ACK_WAIT_MAX) begin
            next_cycle();
            n++;
        end
        if (!o_core_en) begin
            other_errs++;
            $display("step %0d: core did not resume within %0d cycles of the key press",
                     cur_step, ACK_WAIT_MAX);
        end
        repeat (3) next_cycle();  // key stays down.
        check_key_path(s);
    endtask

    task automatic release_key(input step_t s);
        drive_redirect(s);
        i_key_n = 1'b1;
        repeat (4) next_cycle();
        check_key_path(s);
    endtask

    task automatic run_wb(input step_t s);
        int   n;
        logic acked;
        logic ce_seen;
        n = 0;
        acked = 1'b0;
        ce_seen = 1'b0;
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we = (s.kind == K_WB_WRITE);
        i_wb_addr = s.addr;
        i_wb_sel = s.sel;
        i_wb_data = s.data;
        while (!acked && n < ACK_WAIT_MAX) begin
            next_cycle();
            n++;
            acked = o_wb_ack;
            if (!o_sram_ce_n) ce_seen = 1'b1;
        end
        if (!acked) begin
            other_errs++;
            $display("step %0d: no Wishbone ack within %0d cycles", cur_step, ACK_WAIT_MAX);
        end else begin
            check_word("ack cycles", 32'(n), 32'(s.exp_lat));
            check_bit("sram enabled", ce_seen, s.exp_lat == 2'd3);
            if (s.kind == K_WB_READ) check_word("o_wb_data", o_wb_data, s.exp_word);
        end
        next_cycle();
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we = 1'b0;
    endtask

    // --------------------
    // main sequence
    // --------------------

    initial begin
        clk = 1'b0;
        n_rst = 1'b0;
        i_key_n = 1'b1;
        i_retire_en = 1'b0;
        i_retire_rdst = '0;
        i_retire_data = '0;
        i_redirect = 1'b0;
        i_redirect_addr = '0;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we = 1'b0;
        i_wb_cti = '0;
        i_wb_bte = '0;
        i_wb_sel = '0;
        i_wb_addr = '0;
        i_wb_data = '0;
        value_errs = 0;
        other_errs = 0;
        cur_step = -1;
        rand_state = 32'd55;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
        check_bit("o_core_en", o_core_en, 1'b1);
        check_bit("o_ledr[17]", o_ledr[17], 1'b0);
        check_word("o_ledg", 32'(o_ledg), 32'h0);
        check_hex("o_hex", o_hex, {HEX_W{1'b1}});
        check_bit("o_sram_ce_n", o_sram_ce_n, 1'b1);
        check_bit("o_sram_we_n", o_sram_we_n, 1'b1);
        check_bit("o_sram_oe_n", o_sram_oe_n, 1'b1);
        check_bit("o_sram_lb_n", o_sram_lb_n, 1'b1);
        check_bit("o_sram_ub_n", o_sram_ub_n, 1'b1);
        check_bit("o_wb_ack", o_wb_ack, 1'b0);
        for (cur_step = 0; cur_step < NUM_STEPS; cur_step++) begin
            case (steps[cur_step].kind)
                K_RETIRE:   run_retire(steps[cur_step]);
                K_KEY_DOWN: press_key(steps[cur_step]);
                K_KEY_UP:   release_key(steps[cur_step]);
                default:    run_wb(steps[cur_step]);
            endcase
        end
        $display("done: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // about 100 cycles per step.
    initial begin
        repeat (NUM_STEPS * 100) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", NUM_STEPS * 100);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/dbg_pkg.sv
src/dbg_edge_detector.sv
src/dbg_step_ctrl.sv
src/dbg_seg7_bank.sv
src/sram_wb.sv
src/dbg_board_top.sv
dv/sram_model.sv
dv/tb_dbg_board.sv

// File: run.sh
#!/bin/sh
# Build and run the harness testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_dbg_board --Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_dbg_board)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1

// File: src/dbg_board_top.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_board_top #(
    parameter OPTN_DATA_WIDTH        = 32,
    parameter OPTN_RAT_DEPTH         = 32,
    parameter OPTN_ADDR_WIDTH        = 32,
    parameter OPTN_WB_ADDR_WIDTH     = 32,
    parameter OPTN_WB_SRAM_BASE_ADDR = 0
)(
    input  logic                                             clk,
    input  logic                                             n_rst,

    input  logic                                             i_key_n,

    // retire stream from the core.
    input  logic                                             i_retire_en,
    input  logic [$clog2(OPTN_RAT_DEPTH)-1:0]                i_retire_rdst,
    input  logic [OPTN_DATA_WIDTH-1:0]                       i_retire_data,
    input  logic                                             i_redirect,
    input  logic [OPTN_ADDR_WIDTH-1:0]                       i_redirect_addr,

    // wishbone, core is master.
    input  logic                                             i_wb_cyc,
    input  logic                                             i_wb_stb,
    input  logic                                             i_wb_we,
    input  logic [dbg_pkg::WB_CTI_WIDTH-1:0]                 i_wb_cti,
    input  logic [dbg_pkg::WB_BTE_WIDTH-1:0]                 i_wb_bte,
    input  logic [3:0]                                       i_wb_sel,
    input  logic [OPTN_WB_ADDR_WIDTH-1:0]                    i_wb_addr,
    input  logic [31:0]                                      i_wb_data,
    output logic [31:0]                                      o_wb_data,
    output logic                                             o_wb_ack,

    output logic                                             o_core_en,
    output logic [17:0]                                      o_ledr,
    output logic [7:0]                                       o_ledg,
    output logic [dbg_pkg::HEX_DIGITS*dbg_pkg::SEG_WIDTH-1:0] o_hex,

    output logic                                             o_sram_ce_n,
    output logic                                             o_sram_oe_n,
    output logic                                             o_sram_we_n,
    output logic                                             o_sram_lb_n,
    output logic                                             o_sram_ub_n,
    output logic [dbg_pkg::SRAM_ADDR_WIDTH-1:0]              o_sram_addr,
    inout  wire  [dbg_pkg::SRAM_DATA_WIDTH-1:0]              io_sram_dq
);

    localparam int RAT_IDX_WIDTH = $clog2(OPTN_RAT_DEPTH);

    logic                     key_pulse;
    logic                     halted;
    logic                     cap_valid;
    logic [RAT_IDX_WIDTH-1:0] cap_rdst;
    logic [OPTN_DATA_WIDTH-1:0] cap_data;

    // --------------------
    // key path
    // --------------------

    dbg_edge_detector dbg_edge_detector_inst (
        .clk(clk),
        .n_rst(n_rst),
        .i_async(~i_key_n),  // key is active low.
        .o_pulse(key_pulse)
    );

    dbg_step_ctrl #(
        .OPTN_DATA_WIDTH(OPTN_DATA_WIDTH),
        .OPTN_RAT_DEPTH(OPTN_RAT_DEPTH)
    ) dbg_step_ctrl_inst (
        .clk(clk),
        .n_rst(n_rst),
        .i_retire_en(i_retire_en),
        .i_retire_rdst(i_retire_rdst),
        .i_retire_data(i_retire_data),
        .i_step_pulse(key_pulse),
        .o_core_en(o_core_en),
        .o_halted(halted),
        .o_cap_valid(cap_valid),
        .o_cap_rdst(cap_rdst),
        .o_cap_data(cap_data)
    );

    dbg_seg7_bank #(
        .OPTN_DATA_WIDTH(OPTN_DATA_WIDTH)
    ) dbg_seg7_bank_inst (
        .clk(clk),
        .n_rst(n_rst),
        .i_load(cap_valid),
        .i_value(cap_data),
        .o_hex(o_hex)
    );

    // --------------------
    // leds
    // --------------------

    assign o_ledr[17]   = halted;
    assign o_ledr[16]   = i_redirect;
    assign o_ledr[15:0] = i_redirect_addr[15:0];
    assign o_ledg       = {{(8-RAT_IDX_WIDTH){1'b0}}, cap_rdst};

    // --------------------
    // sram bridge
    // --------------------

    sram_wb #(
        .OPTN_WB_ADDR_WIDTH(OPTN_WB_ADDR_WIDTH),
        .OPTN_BASE_ADDR(OPTN_WB_SRAM_BASE_ADDR)
    ) sram_wb_inst (
        .clk(clk),
        .n_rst(n_rst),
        .i_wb_cyc(i_wb_cyc),
        .i_wb_stb(i_wb_stb),
        .i_wb_we(i_wb_we),
        .i_wb_cti(i_wb_cti),
        .i_wb_bte(i_wb_bte),
        .i_wb_sel(i_wb_sel),
        .i_wb_addr(i_wb_addr),
        .i_wb_data(i_wb_data),
        .o_wb_data(o_wb_data),
        .o_wb_ack(o_wb_ack),
        .o_sram_ce_n(o_sram_ce_n),
        .o_sram_oe_n(o_sram_oe_n),
        .o_sram_we_n(o_sram_we_n),
        .o_sram_lb_n(o_sram_lb_n),
        .o_sram_ub_n(o_sram_ub_n),
        .o_sram_addr(o_sram_addr),
        .io_sram_dq(io_sram_dq)
    );

endmodule

`default_nettype wire

// File: src/dbg_edge_detector.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_edge_detector (
    input  logic clk,
    input  logic n_rst,

    input  logic i_async,
    output logic o_pulse
);

    logic sync_q1;
    logic sync_q2;
    logic prev_q;

    // --------------------
    // synchronizer
    // --------------------

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
        end else begin
            sync_q1 <= i_async;  // may go metastable.
            sync_q2 <= sync_q1;
        end
    end

    // --------------------
    // rising edge
    // --------------------

    // last settled level.
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            prev_q <= 1'b0;
        end else begin
            prev_q <= sync_q2;
        end
    end

    // held key gives a single pulse.
    assign o_pulse = sync_q2 & ~prev_q;

endmodule

`default_nettype wire

// File: src/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

    // --------------------
    // board constants
    // --------------------

    localparam int SRAM_ADDR_WIDTH = 20;  // halfword address.
    localparam int SRAM_DATA_WIDTH = 16;

    localparam int WB_CTI_WIDTH = 3;
    localparam int WB_BTE_WIDTH = 2;

    // one digit, active low, a in bit 0.
    localparam int SEG_WIDTH  = 7;
    localparam int HEX_DIGITS = 8;

    // --------------------
    // state encodings
    // --------------------

    // core either runs freely or waits for a key press.
    typedef enum logic [0:0] {
        STEP_RUN  = 1'b0,
        STEP_HALT = 1'b1
    } step_state_e;

    // low halfword goes out first.
    typedef enum logic [1:0] {
        SRAM_IDLE = 2'b00,
        SRAM_LO   = 2'b01,
        SRAM_HI   = 2'b10,
        SRAM_ACK  = 2'b11
    } sram_phase_e;

endpackage

`default_nettype wire

// File: src/dbg_seg7_bank.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_seg7_bank #(
    parameter OPTN_DATA_WIDTH = 32
)(
    input  logic                                             clk,
    input  logic                                             n_rst,

    input  logic                                             i_load,
    input  logic [OPTN_DATA_WIDTH-1:0]                       i_value,
    output logic [dbg_pkg::HEX_DIGITS*dbg_pkg::SEG_WIDTH-1:0] o_hex
);

    import dbg_pkg::*;

    localparam logic [SEG_WIDTH-1:0] SEG_BLANK = 7'h7f;

    // active low, gfedcba.
    function automatic logic [SEG_WIDTH-1:0] hex_to_seg(input logic [3:0] nibble);
        logic [SEG_WIDTH-1:0] seg;
        case (nibble)
            4'h0:    seg = 7'b1000000;
            4'h1:    seg = 7'b1111001;
            4'h2:    seg = 7'b0100100;
            4'h3:    seg = 7'b0110000;
            4'h4:    seg = 7'b0011001;
            4'h5:    seg = 7'b0010010;
            4'h6:    seg = 7'b0000010;
            4'h7:    seg = 7'b1111000;
            4'h8:    seg = 7'b0000000;
            4'h9:    seg = 7'b0010000;
            4'ha:    seg = 7'b0001000;
            4'hb:    seg = 7'b0000011;  // lower case b.
            4'hc:    seg = 7'b1000110;
            4'hd:    seg = 7'b0100001;  // lower case d.
            4'he:    seg = 7'b0000110;
            default: seg = 7'b0001110;
        endcase
        return seg;
    endfunction

    // --------------------
    // digit registers
    // --------------------

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_hex <= {HEX_DIGITS{SEG_BLANK}};
        end else if (i_load) begin
            // digit 0 shows the lowest nibble.
            for (int i = 0; i < HEX_DIGITS; i++) begin
                o_hex[i*SEG_WIDTH +: SEG_WIDTH] <= hex_to_seg(i_value[i*4 +: 4]);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/dbg_step_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_step_ctrl #(
    parameter OPTN_DATA_WIDTH = 32,
    parameter OPTN_RAT_DEPTH  = 32
)(
    input  logic                               clk,
    input  logic                               n_rst,

    input  logic                               i_retire_en,
    input  logic [$clog2(OPTN_RAT_DEPTH)-1:0]  i_retire_rdst,
    input  logic [OPTN_DATA_WIDTH-1:0]         i_retire_data,
    input  logic                               i_step_pulse,

    output logic                               o_core_en,
    output logic                               o_halted,
    output logic                               o_cap_valid,
    output logic [$clog2(OPTN_RAT_DEPTH)-1:0]  o_cap_rdst,
    output logic [OPTN_DATA_WIDTH-1:0]         o_cap_data
);

    import dbg_pkg::*;

    step_state_e state;

    // --------------------
    // run/halt
    // --------------------

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state       <= STEP_RUN;
            o_cap_valid <= 1'b0;
            o_cap_rdst  <= '0;
            o_cap_data  <= '0;
        end else begin
            o_cap_valid <= 1'b0;
            case (state)
                STEP_RUN: begin
                    if (i_retire_en) begin
                        state       <= STEP_HALT;
                        o_cap_valid <= 1'b1;  // display reloads next cycle.
                        o_cap_rdst  <= i_retire_rdst;
                        o_cap_data  <= i_retire_data;
                    end
                end
                STEP_HALT: begin
                    // retires here are dropped.
                    if (i_step_pulse) begin
                        state <= STEP_RUN;
                    end
                end
                default: state <= STEP_RUN;
            endcase
        end
    end

    // straight from the state flop, so the core stops on the capture edge.
    assign o_core_en = (state == STEP_RUN);
    assign o_halted  = (state == STEP_HALT);

endmodule

`default_nettype wire

// File: src/sram_wb.sv
`timescale 1ns/1ps
`default_nettype none

module sram_wb #(
    parameter OPTN_WB_ADDR_WIDTH = 32,
    parameter OPTN_BASE_ADDR     = 0
)(
    input  logic                                clk,
    input  logic                                n_rst,

    // wishbone slave.
    input  logic                                i_wb_cyc,
    input  logic                                i_wb_stb,
    input  logic                                i_wb_we,
    input  logic [dbg_pkg::WB_CTI_WIDTH-1:0]    i_wb_cti,
    input  logic [dbg_pkg::WB_BTE_WIDTH-1:0]    i_wb_bte,
    input  logic [3:0]                          i_wb_sel,
    input  logic [OPTN_WB_ADDR_WIDTH-1:0]       i_wb_addr,
    input  logic [31:0]                         i_wb_data,
    output logic [31:0]                         o_wb_data,
    output logic                                o_wb_ack,

    // async sram.
    output logic                                o_sram_ce_n,
    output logic                                o_sram_oe_n,
    output logic                                o_sram_we_n,
    output logic                                o_sram_lb_n,
    output logic                                o_sram_ub_n,
    output logic [dbg_pkg::SRAM_ADDR_WIDTH-1:0] o_sram_addr,
    inout  wire  [dbg_pkg::SRAM_DATA_WIDTH-1:0] io_sram_dq
);

    import dbg_pkg::*;

    // 2^20 halfwords.
    localparam int WINDOW_BYTES = 2 * (2 ** SRAM_ADDR_WIDTH);

    sram_phase_e                   phase;
    logic [OPTN_WB_ADDR_WIDTH-1:0] offset;
    logic                          in_window;
    logic                          req;
    logic                          active;
    logic                          hi_half;
    logic [1:0]                    lane_sel;
    logic [SRAM_DATA_WIDTH-1:0]    wr_half;
    logic [31:0]                   rdata;

    // --------------------
    // address window
    // --------------------

    assign offset    = i_wb_addr - OPTN_WB_ADDR_WIDTH'(OPTN_BASE_ADDR);
    assign in_window = (i_wb_addr >= OPTN_WB_ADDR_WIDTH'(OPTN_BASE_ADDR)) &&
                       (offset < OPTN_WB_ADDR_WIDTH'(WINDOW_BYTES));

    assign req = i_wb_cyc && i_wb_stb;

    // --------------------
    // phase FSM
    // --------------------

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            phase <= SRAM_IDLE;
        end else begin
            case (phase)
                SRAM_IDLE: begin
                    if (req) begin
                        phase <= in_window ? SRAM_LO : SRAM_ACK;  // miss acks at once.
                    end
                end
                SRAM_LO:  phase <= SRAM_HI;
                SRAM_HI:  phase <= SRAM_ACK;
                default:  phase <= SRAM_IDLE;  // ack lasts one cycle.
            endcase
        end
    end

    // --------------------
    // read assembly
    // --------------------

    always_ff @(posedge clk) begin
        case (phase)
            SRAM_IDLE: begin
                if (req) begin
                    rdata <= '0;  // out of window reads zero.
                end
            end
            SRAM_LO: begin
                if (!i_wb_we) begin
                    rdata[15:0] <= io_sram_dq;
                end
            end
            SRAM_HI: begin
                if (!i_wb_we) begin
                    rdata[31:16] <= io_sram_dq;
                end
            end
            default: ;
        endcase
    end

    assign o_wb_data = rdata;
    assign o_wb_ack  = (phase == SRAM_ACK);

    // --------------------
    // sram pins
    // --------------------

    assign active  = (phase == SRAM_LO) || (phase == SRAM_HI);
    assign hi_half = (phase == SRAM_HI);

    assign lane_sel = hi_half ? i_wb_sel[3:2] : i_wb_sel[1:0];
    assign wr_half  = hi_half ? i_wb_data[31:16] : i_wb_data[15:0];

    assign o_sram_ce_n = ~active;
    assign o_sram_oe_n = ~(active && !i_wb_we);
    assign o_sram_we_n = ~(active && i_wb_we);

    // reads take both lanes, writes only the selected bytes.
    assign o_sram_lb_n = ~(active && (!i_wb_we || lane_sel[0]));
    assign o_sram_ub_n = ~(active && (!i_wb_we || lane_sel[1]));

    // word offset times two, plus the half.
    assign o_sram_addr = {offset[SRAM_ADDR_WIDTH:2], hi_half};

    assign io_sram_dq = (active && i_wb_we) ? wr_half : 'z;

endmodule

`default_nettype wire
